// File: design/cache_pkg.sv
// cache package with the shared address, line, count types and controller states
package cache_pkg;

    // 32-byte lines, so five offset bits
    parameter int s_offset = 5;
    parameter int s_mask   = 2**s_offset;  // bytes per line
    parameter int s_line   = 8*s_mask;     // bits per line

    // byte address from the cpu
    typedef logic [31:0] rv32i_word;

    // one full cache line
    typedef logic [s_line-1:0] line_t;

    // one enable per byte of a line
    typedef logic [s_mask-1:0] byte_en_t;

    // statistics count, wraps
    typedef logic [15:0] count_t;

    // controller states
    typedef enum logic [1:0] {
        s_idle      = 2'b00,
        s_compare   = 2'b01,
        s_writeback = 2'b10,
        s_fill      = 2'b11
    } cache_state_t;

endpackage : cache_pkg

// File: design/cache_array.sv
// cache array, small register file for tag, valid, dirty and lru bits
`timescale 1ns/1ns

module cache_array #(
    parameter int width   = 1,
    parameter int s_index = 3
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  logic [s_index-1:0] rindex,
    input  logic [s_index-1:0] windex,
    input  logic [width-1:0]   datain,
    output logic [width-1:0]   dataout
);

    localparam int num_sets = 2**s_index;

    logic [width-1:0] data [num_sets];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < num_sets; i++)
            begin
                data[i] <= '0;
            end
        end
        else if (load)
        begin
            data[windex] <= datain;
        end
    end

    assign dataout = data[rindex];  // combinational read

endmodule : cache_array

// File: design/cache_line_array.sv
// cache line array, one way's lines with per-byte write enables
`timescale 1ns/1ns

module cache_line_array #(
    parameter int s_index = 3
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  cache_pkg::byte_en_t write_en,
    input  logic [s_index-1:0] index,
    input  cache_pkg::line_t   datain,
    output cache_pkg::line_t   dataout
);

    import cache_pkg::*;

    localparam int num_sets = 2**s_index;

    line_t data [num_sets];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < num_sets; i++)
            begin
                data[i] <= '0;
            end
        end
        else
        begin
            // only enabled bytes change
            for (int b = 0; b < s_mask; b++)
            begin
                if (write_en[b])
                begin
                    data[index][8*b +: 8] <= datain[8*b +: 8];
                end
            end
        end
    end

    assign dataout = data[index];

endmodule : cache_line_array

// File: design/cache_datapath.sv
// cache datapath, tag compare, way select, write steering and per-way arrays
`timescale 1ns/1ns

module cache_datapath #(
    parameter int s_index = 3
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::rv32i_word mem_address,
    input  cache_pkg::line_t    mem_wdata256,
    input  cache_pkg::byte_en_t mem_byte_enable256,
    input  cache_pkg::line_t    pmem_rdata,
    input  logic                load_data,
    input  logic                set_dirty,
    input  logic                clear_dirty,
    input  logic                set_valid,
    input  logic                load_tag,
    input  logic                set_lru,
    input  logic                fill_sel,
    input  logic                wb_addr_sel,
    output logic                hit,
    output logic                dirty,
    output cache_pkg::line_t    mem_rdata256,
    output cache_pkg::line_t    pmem_wdata,
    output cache_pkg::rv32i_word pmem_address
);

    import cache_pkg::*;

    localparam int s_tag = 32 - s_offset - s_index;

    logic [s_tag-1:0]   set_tag;
    logic [s_index-1:0] set_idx;
    logic [s_tag-1:0]   t0, t1;
    logic [s_tag-1:0]   victim_tag;
    logic               v0, v1;
    logic               d0, d1;
    logic               h0, h1;
    logic               lru_out;  // way to replace next
    logic               lru_in;
    logic               tl_0, tl_1;
    logic               vl_0, vl_1;
    logic               dl_0, dl_1;
    logic               dirty_in;
    byte_en_t           we_0, we_1;
    line_t              line_in;
    line_t              line_out0, line_out1;

    assign set_tag = mem_address[31 -: s_tag];
    assign set_idx = mem_address[s_offset +: s_index];

    assign h0  = v0 && (t0 == set_tag);
    assign h1  = v1 && (t1 == set_tag);
    assign hit = h0 || h1;

    assign dirty      = lru_out ? d1 : d0;
    assign victim_tag = lru_out ? t1 : t0;
    assign lru_in     = h0;  // point at the way that missed

    // fills go to the victim, cpu writes to the hit way
    assign line_in = fill_sel ? pmem_rdata : mem_wdata256;

    always_comb
    begin
        we_0 = '0;
        we_1 = '0;
        if (load_data)
        begin
            if (fill_sel)
            begin
                if (lru_out)
                    we_1 = '1;
                else
                    we_0 = '1;
            end
            else
            begin
                if (h0)
                    we_0 = mem_byte_enable256;
                if (h1)
                    we_1 = mem_byte_enable256;
            end
        end
    end

    assign tl_0 = load_tag && !lru_out;
    assign tl_1 = load_tag && lru_out;
    assign vl_0 = set_valid && !lru_out;
    assign vl_1 = set_valid && lru_out;

    // set on the hit way, clear on the victim
    assign dl_0     = (set_dirty && h0) || (clear_dirty && !lru_out);
    assign dl_1     = (set_dirty && h1) || (clear_dirty && lru_out);
    assign dirty_in = set_dirty;

    assign mem_rdata256 = h1 ? line_out1 : line_out0;
    assign pmem_wdata   = lru_out ? line_out1 : line_out0;

    assign pmem_address = wb_addr_sel ? {victim_tag, set_idx, {s_offset{1'b0}}}
                                      : {mem_address[31:s_offset], {s_offset{1'b0}}};

    cache_line_array #(.s_index(s_index)) line_array_0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .write_en(we_0),
        .index   (set_idx),
        .datain  (line_in),
        .dataout (line_out0)
    );

    cache_line_array #(.s_index(s_index)) line_array_1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .write_en(we_1),
        .index   (set_idx),
        .datain  (line_in),
        .dataout (line_out1)
    );

    cache_array #(.width(s_tag), .s_index(s_index)) tag_array_0 (
        .clk(clk), .rst_n(rst_n), .load(tl_0), .rindex(set_idx), .windex(set_idx),
        .datain(set_tag), .dataout(t0)
    );

    cache_array #(.width(s_tag), .s_index(s_index)) tag_array_1 (
        .clk(clk), .rst_n(rst_n), .load(tl_1), .rindex(set_idx), .windex(set_idx),
        .datain(set_tag), .dataout(t1)
    );

    cache_array #(.width(1), .s_index(s_index)) valid_array_0 (
        .clk(clk), .rst_n(rst_n), .load(vl_0), .rindex(set_idx), .windex(set_idx),
        .datain(1'b1), .dataout(v0)
    );

    cache_array #(.width(1), .s_index(s_index)) valid_array_1 (
        .clk(clk), .rst_n(rst_n), .load(vl_1), .rindex(set_idx), .windex(set_idx),
        .datain(1'b1), .dataout(v1)
    );

    cache_array #(.width(1), .s_index(s_index)) dirty_array_0 (
        .clk(clk), .rst_n(rst_n), .load(dl_0), .rindex(set_idx), .windex(set_idx),
        .datain(dirty_in), .dataout(d0)
    );

    cache_array #(.width(1), .s_index(s_index)) dirty_array_1 (
        .clk(clk), .rst_n(rst_n), .load(dl_1), .rindex(set_idx), .windex(set_idx),
        .datain(dirty_in), .dataout(d1)
    );

    cache_array #(.width(1), .s_index(s_index)) lru_array (
        .clk(clk), .rst_n(rst_n), .load(set_lru), .rindex(set_idx), .windex(set_idx),
        .datain(lru_in), .dataout(lru_out)
    );

endmodule : cache_datapath

// File: design/cache_control.sv
// cache controller FSM, orders compare, writeback and fill and flags hit or miss
`timescale 1ns/1ns

module cache_control (
    input  logic clk,
    input  logic rst_n,
    input  logic mem_read,
    input  logic mem_write,
    input  logic hit,
    input  logic dirty,
    input  logic pmem_resp,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output logic load_data,
    output logic set_dirty,
    output logic clear_dirty,
    output logic set_valid,
    output logic load_tag,
    output logic set_lru,
    output logic fill_sel,
    output logic wb_addr_sel,
    output logic count_hit,
    output logic count_miss
);

    import cache_pkg::*;

    cache_state_t state, next_state;
    logic         missed;  // current request already missed once
    logic         missed_next;

    always_comb
    begin
        next_state  = state;
        missed_next = missed;
        mem_resp    = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        load_data   = 1'b0;
        set_dirty   = 1'b0;
        clear_dirty = 1'b0;
        set_valid   = 1'b0;
        load_tag    = 1'b0;
        set_lru     = 1'b0;
        fill_sel    = 1'b0;
        wb_addr_sel = 1'b0;
        count_hit   = 1'b0;
        count_miss  = 1'b0;

        unique case (state)
            s_idle:
            begin
                if (mem_read || mem_write)
                    next_state = s_compare;
            end
            s_compare:
            begin
                if (hit)
                begin
                    mem_resp    = 1'b1;
                    set_lru     = 1'b1;
                    load_data   = mem_write;  // merge enabled bytes
                    set_dirty   = mem_write;
                    count_hit   = !missed;
                    missed_next = 1'b0;
                    next_state  = s_idle;
                end
                else
                begin
                    count_miss  = !missed;
                    missed_next = 1'b1;
                    next_state  = dirty ? s_writeback : s_fill;
                end
            end
            s_writeback:
            begin
                pmem_write  = 1'b1;
                wb_addr_sel = 1'b1;  // victim address
                if (pmem_resp)
                    next_state = s_fill;
            end
            s_fill:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    load_data   = 1'b1;
                    fill_sel    = 1'b1;
                    load_tag    = 1'b1;
                    set_valid   = 1'b1;
                    clear_dirty = 1'b1;
                    next_state  = s_compare;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= s_idle;
            missed <= 1'b0;
        end
        else
        begin
            state  <= next_state;
            missed <= missed_next;
        end
    end

endmodule : cache_control

// File: design/cache_stats.sv
// cache statistics, hit and miss counts per cpu request
`timescale 1ns/1ns

module cache_stats (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              count_hit,
    input  logic              count_miss,
    output cache_pkg::count_t hit_count,
    output cache_pkg::count_t miss_count
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hit_count  <= '0;
            miss_count <= '0;
        end
        else
        begin
            if (count_hit)
                hit_count <= hit_count + 1'b1;  // wraps
            if (count_miss)
                miss_count <= miss_count + 1'b1;
        end
    end

endmodule : cache_stats

// File: design/cache_top.sv
// cache top, two-way write-back cache between cpu line port and physical memory
`timescale 1ns/1ns

module cache_top #(
    parameter int s_index = 3
)
(
    input  logic                clk,
    input  logic                rst_n,
    // cpu side
    input  logic                mem_read,
    input  logic                mem_write,
    input  cache_pkg::rv32i_word mem_address,
    input  cache_pkg::line_t    mem_wdata256,
    input  cache_pkg::byte_en_t mem_byte_enable256,
    output cache_pkg::line_t    mem_rdata256,
    output logic                mem_resp,
    // memory side
    output logic                pmem_read,
    output logic                pmem_write,
    output cache_pkg::rv32i_word pmem_address,
    output cache_pkg::line_t    pmem_wdata,
    input  cache_pkg::line_t    pmem_rdata,
    input  logic                pmem_resp,
    // statistics
    output cache_pkg::count_t   hit_count,
    output cache_pkg::count_t   miss_count
);

    logic load_data, set_dirty, clear_dirty, set_valid;
    logic load_tag, set_lru, fill_sel, wb_addr_sel;
    logic hit, dirty;
    logic count_hit, count_miss;

    cache_control control (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .hit        (hit),
        .dirty      (dirty),
        .pmem_resp  (pmem_resp),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .load_data  (load_data),
        .set_dirty  (set_dirty),
        .clear_dirty(clear_dirty),
        .set_valid  (set_valid),
        .load_tag   (load_tag),
        .set_lru    (set_lru),
        .fill_sel   (fill_sel),
        .wb_addr_sel(wb_addr_sel),
        .count_hit  (count_hit),
        .count_miss (count_miss)
    );

    cache_datapath #(.s_index(s_index)) datapath (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_address       (mem_address),
        .mem_wdata256      (mem_wdata256),
        .mem_byte_enable256(mem_byte_enable256),
        .pmem_rdata        (pmem_rdata),
        .load_data         (load_data),
        .set_dirty         (set_dirty),
        .clear_dirty       (clear_dirty),
        .set_valid         (set_valid),
        .load_tag          (load_tag),
        .set_lru           (set_lru),
        .fill_sel          (fill_sel),
        .wb_addr_sel       (wb_addr_sel),
        .hit               (hit),
        .dirty             (dirty),
        .mem_rdata256      (mem_rdata256),
        .pmem_wdata        (pmem_wdata),
        .pmem_address      (pmem_address)
    );

    cache_stats stats (
        .clk       (clk),
        .rst_n     (rst_n),
        .count_hit (count_hit),
        .count_miss(count_miss),
        .hit_count (hit_count),
        .miss_count(miss_count)
    );

endmodule : cache_top

// File: tests/cache_pmem_model.sv
// physical memory model, line storage answering after a random delay
`timescale 1ns/1ns

module cache_pmem_model #(
    parameter int num_lines = 64
)
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pmem_read,
    input  logic                 pmem_write,
    input  cache_pkg::rv32i_word pmem_address,
    input  cache_pkg::line_t     pmem_wdata,
    output cache_pkg::line_t     pmem_rdata,
    output logic                 pmem_resp
);

    import cache_pkg::*;

    localparam int s_line_idx = $clog2(num_lines);

    line_t                 mem [num_lines];
    logic                  busy;
    int                    wait_cnt;
    logic [s_line_idx-1:0] idx;

    assign idx = pmem_address[s_offset +: s_line_idx];

    // each word holds its own byte address, scrambled
    initial
    begin
        for (int i = 0; i < num_lines; i++)
            for (int w = 0; w < 8; w++)
                mem[i][32*w +: 32] = (32*i + 4*w) ^ 32'h5a5a_0000;
    end

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy       <= 1'b0;
            wait_cnt   <= 0;
            pmem_resp  <= 1'b0;
            pmem_rdata <= '0;
        end
        else if (pmem_resp)
        begin
            pmem_resp <= 1'b0;  // one-cycle pulse
        end
        else if (!busy)
        begin
            if (pmem_read || pmem_write)
            begin
                busy     <= 1'b1;
                wait_cnt <= 1 + int'($urandom % 4);  // 1 to 4 cycles
            end
        end
        else if (wait_cnt > 1)
        begin
            wait_cnt <= wait_cnt - 1;
        end
        else
        begin
            busy      <= 1'b0;
            pmem_resp <= 1'b1;
            if (pmem_write)
                mem[idx] <= pmem_wdata;
            else
                pmem_rdata <= mem[idx];
        end
    end

endmodule : cache_pmem_model

// File: tests/cache_tb.sv
// cache testbench, table-driven cpu requests checked against a shadow cache model
`timescale 1ns/1ns

module cache_tb;

    import cache_pkg::*;

    localparam int s_index      = 3;
    localparam int s_tag        = 32 - s_offset - s_index;
    localparam int num_sets     = 2**s_index;
    localparam int num_lines    = 64;
    localparam int s_mem_idx    = 6;
    localparam int n_entries    = 12;
    localparam int max_delay    = 4;
    localparam int worst_cycles = 2*(max_delay + 2) + 10;  // writeback plus fill
    localparam int reset_cycles = 16;

    logic        clk;
    logic        rst_n;
    logic        mem_read;
    logic        mem_write;
    rv32i_word   mem_address;
    line_t       mem_wdata256;
    byte_en_t    mem_byte_enable256;
    line_t       mem_rdata256;
    logic        mem_resp;
    logic        pmem_read;
    logic        pmem_write;
    logic        pmem_resp;
    rv32i_word   pmem_address;
    line_t       pmem_wdata;
    line_t       pmem_rdata;
    count_t      hit_count;
    count_t      miss_count;

    // stimulus table
    string       t_name  [n_entries];
    logic        t_write [n_entries];
    rv32i_word   t_addr  [n_entries];
    line_t       t_wdata [n_entries];
    byte_en_t    t_be    [n_entries];
    logic        t_miss  [n_entries];  // expected line fetch

    // shadow cache and memory
    logic [s_tag-1:0] sh_tag [2][num_sets];
    logic        sh_valid [2][num_sets];
    logic        sh_dirty [2][num_sets];
    logic        sh_lru   [num_sets];
    line_t       sh_line  [2][num_sets];
    line_t       sh_mem   [num_lines];

    rv32i_word   exp_wb_addr [$];
    line_t       exp_wb_data [$];
    rv32i_word   got_wb_addr [$];
    line_t       got_wb_data [$];
    rv32i_word   fill_addr;  // address of the last line fetch
    int          fetches;
    int          errors;
    int          exp_hits;
    int          exp_misses;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    cache_top #(.s_index(s_index)) dut (
        .clk(clk), .rst_n(rst_n),
        .mem_read(mem_read), .mem_write(mem_write), .mem_address(mem_address),
        .mem_wdata256(mem_wdata256), .mem_byte_enable256(mem_byte_enable256),
        .mem_rdata256(mem_rdata256), .mem_resp(mem_resp),
        .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp),
        .hit_count(hit_count), .miss_count(miss_count)
    );

    cache_pmem_model #(.num_lines(num_lines)) pmem (
        .clk(clk), .rst_n(rst_n),
        .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
    );

    // memory transfers, sampled mid-cycle
    always @(negedge clk)
    begin
        if (pmem_resp && pmem_write)
        begin
            got_wb_addr.push_back(pmem_address);
            got_wb_data.push_back(pmem_wdata);
        end
        if (pmem_resp && pmem_read)
        begin
            fetches++;
            fill_addr = pmem_address;
        end
    end

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp)
        begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input rv32i_word exp, input rv32i_word act);
        if (act !== exp)
        begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp)
        begin
            errors++;
            $display("error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic line_t pattern_line(input int line_no);
        line_t l;
        for (int w = 0; w < 8; w++)
            l[32*w +: 32] = (32*line_no + 4*w) ^ 32'h5a5a_0000;
        return l;
    endfunction

    function automatic line_t make_data(input logic [31:0] base);
        line_t l;
        for (int w = 0; w < 8; w++)
            l[32*w +: 32] = base + 32'h0101_0101 * w;
        return l;
    endfunction

    function automatic int line_index(input rv32i_word a);
        return int'(a[s_offset +: s_mem_idx]);
    endfunction

    task automatic add_entry(input int i, input string name, input logic wr,
                             input rv32i_word addr, input line_t wdata,
                             input byte_en_t be, input logic miss);
        t_name[i]  = name;
        t_write[i] = wr;
        t_addr[i]  = addr;
        t_wdata[i] = wdata;
        t_be[i]    = be;
        t_miss[i]  = miss;
    endtask

    // shadow cache, same replacement and write rules as the design
    task automatic predict_access(input logic wr, input rv32i_word addr, input line_t wdata,
                                  input byte_en_t be, output line_t rdata);
        logic [s_index-1:0] idx;
        logic [s_tag-1:0]   tag;
        rv32i_word          victim_addr;
        int                 way;
        idx = addr[s_offset +: s_index];
        tag = addr[31 -: s_tag];
        way = -1;
        for (int w = 0; w < 2; w++)
            if (sh_valid[w][idx] && sh_tag[w][idx] == tag)
                way = w;
        if (way >= 0)
            exp_hits++;
        else
        begin
            exp_misses++;
            way = int'(sh_lru[idx]);
            if (sh_dirty[way][idx])
            begin
                victim_addr = {sh_tag[way][idx], idx, {s_offset{1'b0}}};
                exp_wb_addr.push_back(victim_addr);
                exp_wb_data.push_back(sh_line[way][idx]);
                sh_mem[line_index(victim_addr)] = sh_line[way][idx];
            end
            sh_line[way][idx]  = sh_mem[line_index(addr)];
            sh_tag[way][idx]   = tag;
            sh_valid[way][idx] = 1'b1;
            sh_dirty[way][idx] = 1'b0;
        end
        if (wr)
        begin
            for (int b = 0; b < s_mask; b++)
                if (be[b])
                    sh_line[way][idx][8*b +: 8] = wdata[8*b +: 8];
            sh_dirty[way][idx] = 1'b1;
        end
        sh_lru[idx] = (way == 0);  // other way goes next
        rdata = sh_line[way][idx];
    endtask

    // called 2 ns after a rising edge, returns at the same point
    task automatic apply_request(input int i);
        line_t     exp_rdata;
        line_t     act_rdata;
        line_t     exp_line;
        line_t     got_line;
        rv32i_word exp_a;
        rv32i_word got_a;
        predict_access(t_write[i], t_addr[i], t_wdata[i], t_be[i], exp_rdata);
        fetches            = 0;
        mem_read           = !t_write[i];
        mem_write          = t_write[i];
        mem_address        = t_addr[i];
        mem_wdata256       = t_wdata[i];
        mem_byte_enable256 = t_be[i];
        do
            @(negedge clk);
        while (!mem_resp);
        act_rdata = mem_rdata256;
        @(posedge clk);
        #2;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        if (!t_write[i])
            check_line(t_name[i], exp_rdata, act_rdata);
        check_count({t_name[i], " fetches"}, count_t'(t_miss[i]), count_t'(fetches));
        if (t_miss[i])
            check_addr({t_name[i], " fill address"}, t_addr[i] & ~rv32i_word'(s_mask - 1),
                       fill_addr);
        if (got_wb_addr.size() != exp_wb_addr.size())
        begin
            errors++;
            $display("error %s: expected %0d writebacks but saw %0d", t_name[i],
                     exp_wb_addr.size(), got_wb_addr.size());
        end
        while (got_wb_addr.size() > 0 && exp_wb_addr.size() > 0)
        begin
            exp_a    = exp_wb_addr.pop_front();
            got_a    = got_wb_addr.pop_front();
            exp_line = exp_wb_data.pop_front();
            got_line = got_wb_data.pop_front();
            check_addr({t_name[i], " wb address"}, exp_a, got_a);
            check_line({t_name[i], " wb data"}, exp_line, got_line);
        end
        got_wb_addr.delete();
        got_wb_data.delete();
        exp_wb_addr.delete();
        exp_wb_data.delete();
        check_count({t_name[i], " hit count"}, count_t'(exp_hits), hit_count);
        check_count({t_name[i], " miss count"}, count_t'(exp_misses), miss_count);
    endtask

    initial
    begin
        void'($urandom(32'hcb939ed6));
        errors             = 0;
        exp_hits           = 0;
        exp_misses         = 0;
        fetches            = 0;
        fill_addr          = '0;
        rst_n              = 1'b0;
        mem_read           = 1'b0;
        mem_write          = 1'b0;
        mem_address        = '0;
        mem_wdata256       = '0;
        mem_byte_enable256 = '0;
        for (int s = 0; s < num_sets; s++)
        begin
            sh_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++)
            begin
                sh_tag[w][s]   = '0;
                sh_valid[w][s] = 1'b0;
                sh_dirty[w][s] = 1'b0;
                sh_line[w][s]  = '0;
            end
        end
        for (int i = 0; i < num_lines; i++)
            sh_mem[i] = pattern_line(i);

        // set 1 holds a, b and c; d and e sit in other sets
        add_entry(0, "rd_miss_a", 1'b0, 32'h0020, '0, '0, 1'b1);
        add_entry(1, "rd_hit_a", 1'b0, 32'h0020, '0, '0, 1'b0);
        add_entry(2, "wr_hit_a_partial", 1'b1, 32'h0020, make_data(32'hc0de_0000),
                  32'h0000_0ff0, 1'b0);
        add_entry(3, "rd_merged_a", 1'b0, 32'h0020, '0, '0, 1'b0);
        add_entry(4, "wr_miss_b", 1'b1, 32'h0120, make_data(32'h7100_0000),
                  32'hff00_000f, 1'b1);
        add_entry(5, "rd_touch_a", 1'b0, 32'h0020, '0, '0, 1'b0);
        add_entry(6, "rd_miss_c_evict_b", 1'b0, 32'h0220, '0, '0, 1'b1);
        add_entry(7, "rd_hit_c", 1'b0, 32'h0220, '0, '0, 1'b0);
        add_entry(8, "rd_miss_b_evict_a", 1'b0, 32'h0120, '0, '0, 1'b1);
        add_entry(9, "wr_miss_d", 1'b1, 32'h0040, make_data(32'h3300_0000), '1, 1'b1);
        add_entry(10, "rd_hit_d", 1'b0, 32'h0040, '0, '0, 1'b0);
        add_entry(11, "rd_miss_e_unaligned", 1'b0, 32'h07e4, '0, '0, 1'b1);

        repeat (reset_cycles)
        begin
            @(negedge clk);
            if (mem_resp || pmem_read || pmem_write)
            begin
                errors++;
                $display("error: cache drives a response or memory request during reset");
            end
        end
        @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (3)
        begin
            @(negedge clk);
            if (mem_resp || pmem_read || pmem_write)
            begin
                errors++;
                $display("error: cache became active with no cpu request");
            end
        end
        check_count("reset hit count", '0, hit_count);
        check_count("reset miss count", '0, miss_count);
        @(posedge clk);
        #2;

        for (int i = 0; i < n_entries; i++)
            apply_request(i);

        repeat (2) @(posedge clk);
        #2;
        check_count("final hit count", count_t'(exp_hits), hit_count);
        check_count("final miss count", count_t'(exp_misses), miss_count);
        for (int i = 0; i < num_lines; i++)
            check_line($sformatf("memory line %0d", i), sh_mem[i], pmem.mem[i]);

        $display("errors: %0d, hits: %0d, misses: %0d", errors, hit_count, miss_count);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // watchdog, sized from the table length
    initial
    begin
        #((reset_cycles + 20 + n_entries * worst_cycles) * 20);
        $display("timeout: the cache stopped answering requests");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : cache_tb

// File: cache.f
design/cache_pkg.sv
design/cache_array.sv
design/cache_line_array.sv
design/cache_datapath.sv
design/cache_control.sv
design/cache_stats.sv
design/cache_top.sv
tests/cache_pmem_model.sv
tests/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cache_tb -f cache.f -o cache_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/cache_sim > sim.log 2>&1
cat sim.log

grep -q "\*\*\* TEST PASSED \*\*\*" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
